/* hw/rv_fetch_pkg.sv */
package rv_fetch_pkg;

  // Address width and first fetch address
  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // BTB geometry
  // Index from PC bits 5:2, tag is everything above the index
  localparam int BTB_IDX_W = 4;
  localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
  localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 2;

  // RAS geometry, depth must be a power of two for pointer wrap
  localparam int RAS_PTR_W = 3;
  localparam int RAS_DEPTH = 1 << RAS_PTR_W;

  // Next-PC source selector
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_PREDICTED  = 2'b01,
    PC_SEL_REDIRECT   = 2'b10
  } pc_sel_t;

  // Kind of control transfer held in a BTB entry
  typedef enum logic [1:0] {
    BTB_BRANCH = 2'b00,
    BTB_CALL   = 2'b01,
    BTB_RETURN = 2'b10
  } btb_kind_t;

  // PC pair registered toward IF
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
  } pc_pair_t;

  // Prediction metadata registered toward IF
  typedef struct packed {
    logic            btb_hit;
    logic            btb_taken;
    logic            btb_is_return;
    logic            ras_valid;
    logic [XLEN-1:0] btb_tgt;
    logic [XLEN-1:0] ras_tgt;
  } pred_meta_t;

endpackage

/* hw/rv_pred_if.sv */
`timescale 1ns/1ps

interface rv_pred_if
  import rv_fetch_pkg::*;
();

  // BTB lookup result for the current PC
  logic            btb_hit;
  logic            btb_taken;
  logic            btb_is_return;
  logic [XLEN-1:0] btb_tgt;
  // Hit on a CALL entry, only the selector needs it for the RAS push
  logic            btb_is_call;

  // Top of the return address stack
  logic            ras_valid;
  logic [XLEN-1:0] ras_tgt;

  // Predictors drive their own fields
  modport producer (
    output btb_hit, btb_taken, btb_is_return, btb_tgt, btb_is_call,
    output ras_valid, ras_tgt
  );

  // Selector and PC stage read the whole bundle
  modport consumer (
    input btb_hit, btb_taken, btb_is_return, btb_tgt, btb_is_call,
    input ras_valid, ras_tgt
  );

endinterface

/* hw/rv_btb.sv */
`timescale 1ns/1ps

module rv_btb
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // Lookup on the raw PC register
  input  logic [XLEN-1:0] lookup_pc_i,

  // Training writes from execute
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic [XLEN-1:0] upd_tgt_i,
  input  btb_kind_t       upd_kind_i,

  rv_pred_if.producer     pred
);

  // Entry storage
  // Only the valid bits carry reset
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q  [BTB_ENTRIES];
  logic [XLEN-1:0]        tgt_q  [BTB_ENTRIES];
  btb_kind_t              kind_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lk_idx;
  logic [BTB_TAG_W-1:0] lk_tag;
  logic [BTB_IDX_W-1:0] upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;
  logic                 lk_hit;

  // Word-aligned index with the tag from the bits above it
  assign lk_idx  = lookup_pc_i[BTB_IDX_W+1:2];
  assign lk_tag  = lookup_pc_i[XLEN-1:BTB_IDX_W+2];
  assign upd_idx = upd_pc_i[BTB_IDX_W+1:2];
  assign upd_tag = upd_pc_i[XLEN-1:BTB_IDX_W+2];

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Entry payload is written on update regardless of stalls
  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[upd_idx]  <= upd_tag;
      tgt_q[upd_idx]  <= upd_tgt_i;
      kind_q[upd_idx] <= upd_kind_i;
    end
  end

  // Combinational lookup
  // A new entry is visible the cycle after its update edge
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  assign pred.btb_hit       = lk_hit;
  // Branches and calls in the BTB are always predicted taken
  assign pred.btb_taken     = lk_hit && (kind_q[lk_idx] != BTB_RETURN);
  assign pred.btb_is_call   = lk_hit && (kind_q[lk_idx] == BTB_CALL);
  assign pred.btb_is_return = lk_hit && (kind_q[lk_idx] == BTB_RETURN);
  assign pred.btb_tgt       = tgt_q[lk_idx];

  // A trained entry is seen by a lookup of the same PC on the next cycle
  a_upd_visible: assert property (
    @(posedge clk) disable iff (!rst_n)
    upd_valid_i |=> (lookup_pc_i != $past(upd_pc_i))
                    || (pred.btb_hit && (pred.btb_tgt == $past(upd_tgt_i)))
  );

endmodule

/* hw/rv_ras.sv */
`timescale 1ns/1ps

module rv_ras
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // Strobes from the selector, already qualified by advance
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] push_addr_i,

  rv_pred_if.producer     pred
);

  // Circular storage, no reset on the entries
  logic [XLEN-1:0] stack_q [RAS_DEPTH];

  // Top points at the most recent entry
  logic [RAS_PTR_W-1:0] top_q;
  // Count saturates at the depth
  logic [RAS_PTR_W:0]   count_q;
  logic [RAS_PTR_W-1:0] top_inc;
  logic                 empty;
  logic                 full;

  assign top_inc = top_q + 1'b1;
  assign empty   = (count_q == '0);
  assign full    = (count_q == (RAS_PTR_W + 1)'(RAS_DEPTH));

  // Pointer and count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (push_i) begin
      top_q <= top_inc;
      // On overflow the oldest entry gets overwritten
      if (!full) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop_i && !empty) begin
      top_q   <= top_q - 1'b1;
      count_q <= count_q - 1'b1;
    end
  end

  // Entry write on push
  always_ff @(posedge clk) begin
    if (push_i) begin
      stack_q[top_inc] <= push_addr_i;
    end
  end

  assign pred.ras_valid = !empty;
  assign pred.ras_tgt   = stack_q[top_q];

  // Selector never asks for both in one cycle
  a_push_pop_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(push_i && pop_i)
  );

endmodule

/* hw/rv_pc_sel.sv */
`timescale 1ns/1ps

module rv_pc_sel
  import rv_fetch_pkg::*;
(
  // Current PC register value
  input  logic [XLEN-1:0] pc_i,

  // Stage advance and execute redirect
  input  logic            advance_i,
  input  logic            redirect_valid_i,
  input  logic [XLEN-1:0] redirect_tgt_i,

  rv_pred_if.consumer     pred,

  // Toward the PC stage
  output pc_sel_t         pc_sel_o,
  output logic [XLEN-1:0] pred_tgt_o,
  output logic [XLEN-1:0] redir_tgt_o,

  // Toward the RAS
  output logic            ras_push_o,
  output logic            ras_pop_o,
  output logic [XLEN-1:0] ras_push_addr_o
);

  logic ret_pred;
  logic btb_pred;
  logic accept;

  // Return predicted only with something on the stack
  // An empty stack leaves a RETURN hit sequential
  assign ret_pred = pred.btb_is_return && pred.ras_valid;
  assign btb_pred = pred.btb_taken;

  // Strobes only count on an accepted, non-redirected cycle
  assign accept = advance_i && !redirect_valid_i;

  // Priority: redirect, then return, then branch or call
  always_comb begin
    pc_sel_o   = PC_SEL_SEQUENTIAL;
    pred_tgt_o = pred.btb_tgt;
    if (redirect_valid_i) begin
      pc_sel_o = PC_SEL_REDIRECT;
    end else if (ret_pred) begin
      pc_sel_o   = PC_SEL_PREDICTED;
      pred_tgt_o = pred.ras_tgt;
    end else if (btb_pred) begin
      pc_sel_o = PC_SEL_PREDICTED;
    end
  end

  assign redir_tgt_o = redirect_tgt_i;

  // Call pushes its return address, return pops
  // CALL and RETURN kinds exclude each other, so no double strobe
  assign ras_push_o      = accept && pred.btb_is_call;
  assign ras_pop_o       = accept && ret_pred;
  assign ras_push_addr_o = pc_i + XLEN'(4);

endmodule

/* hw/rv_pipe_reg.sv */
`timescale 1ns/1ps

module rv_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,

  // Load enable, low holds the current value
  input  logic advance_i,

  input  T     data_i,
  output T     data_o
);

  // Clears to all zeros regardless of payload type
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_o <= '0;
    end else if (advance_i) begin
      data_o <= data_i;
    end
  end

endmodule

/* hw/rv_stage_pc.sv */
`timescale 1ns/1ps

module rv_stage_pc
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // From the selector
  input  pc_sel_t         pc_sel_i,
  input  logic [XLEN-1:0] redir_tgt_i,
  input  logic [XLEN-1:0] pred_tgt_i,

  // Prediction bundle seen at the current PC
  rv_pred_if.consumer     pred,

  input  logic            fetch_ready_i,

  // Raw PC register, drives the predictors
  output logic [XLEN-1:0] pc_o,

  // Registered toward IF
  output logic            fetch_valid_o,
  output logic [XLEN-1:0] pc_if_o,
  output logic [XLEN-1:0] pc_next_if_o,
  output logic            btb_hit_if_o,
  output logic            btb_taken_if_o,
  output logic [XLEN-1:0] btb_tgt_if_o,
  output logic            btb_is_return_if_o,
  output logic            ras_valid_if_o,
  output logic [XLEN-1:0] ras_tgt_if_o,
  output logic            redir_pending_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  pc_pair_t        pair_d;
  pc_pair_t        pair_q;
  pred_meta_t      meta_d;
  pred_meta_t      meta_q;
  logic            redir_d;

  // Next-PC mux
  always_comb begin
    case (pc_sel_i)
      PC_SEL_REDIRECT:  pc_next = redir_tgt_i;
      PC_SEL_PREDICTED: pc_next = pred_tgt_i;
      default:          pc_next = pc_q + XLEN'(4);
    endcase
  end

  // PC register, moves only on accepted cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (fetch_ready_i) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // Source stage, valid from the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid_o <= 1'b0;
    end else begin
      fetch_valid_o <= 1'b1;
    end
  end

  // Pack PC pair and metadata
  assign pair_d.pc      = pc_q;
  assign pair_d.pc_next = pc_next;

  assign meta_d.btb_hit       = pred.btb_hit;
  assign meta_d.btb_taken     = pred.btb_taken;
  assign meta_d.btb_is_return = pred.btb_is_return;
  assign meta_d.ras_valid     = pred.ras_valid;
  assign meta_d.btb_tgt       = pred.btb_tgt;
  assign meta_d.ras_tgt       = pred.ras_tgt;

  // All predictions are early, so only execute redirects flag a flush
  assign redir_d = (pc_sel_i == PC_SEL_REDIRECT);

  // PC-to-IF registers
  rv_pipe_reg #(.T(pc_pair_t)) u_pipe_pc (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(fetch_ready_i),
    .data_i   (pair_d),
    .data_o   (pair_q)
  );

  rv_pipe_reg #(.T(pred_meta_t)) u_pipe_meta (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(fetch_ready_i),
    .data_i   (meta_d),
    .data_o   (meta_q)
  );

  rv_pipe_reg #(.T(logic)) u_pipe_redir (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(fetch_ready_i),
    .data_i   (redir_d),
    .data_o   (redir_pending_o)
  );

  // Unpack toward IF
  assign pc_if_o            = pair_q.pc;
  assign pc_next_if_o       = pair_q.pc_next;
  assign btb_hit_if_o       = meta_q.btb_hit;
  assign btb_taken_if_o     = meta_q.btb_taken;
  assign btb_is_return_if_o = meta_q.btb_is_return;
  assign ras_valid_if_o     = meta_q.ras_valid;
  assign btb_tgt_if_o       = meta_q.btb_tgt;
  assign ras_tgt_if_o       = meta_q.ras_tgt;

  // IF side holds still while IF stalls
  a_stall_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    !fetch_ready_i |=> $stable(pc_if_o) && $stable(pc_next_if_o) && $stable(pc_o)
  );

endmodule

/* hw/rv_fetch_top.sv */
`timescale 1ns/1ps

module rv_fetch_top
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // IF back-pressure
  input  logic            fetch_ready_i,

  // Execute redirect, held until accepted
  input  logic            redirect_valid_i,
  input  logic [XLEN-1:0] redirect_tgt_i,

  // BTB training
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic [XLEN-1:0] upd_tgt_i,
  input  btb_kind_t       upd_kind_i,

  // Toward IF
  output logic            fetch_valid_o,
  output logic [XLEN-1:0] pc_if_o,
  output logic [XLEN-1:0] pc_next_if_o,
  output logic            btb_hit_if_o,
  output logic            btb_taken_if_o,
  output logic [XLEN-1:0] btb_tgt_if_o,
  output logic            btb_is_return_if_o,
  output logic            ras_valid_if_o,
  output logic [XLEN-1:0] ras_tgt_if_o,
  output logic            redir_pending_o
);

  logic [XLEN-1:0] pc;
  pc_sel_t         pc_sel;
  logic [XLEN-1:0] pred_tgt;
  logic [XLEN-1:0] redir_tgt;
  logic            ras_push;
  logic            ras_pop;
  logic [XLEN-1:0] ras_push_addr;

  // Prediction bundle shared by both predictors
  rv_pred_if u_pred ();

  rv_btb u_btb (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup_pc_i(pc),
    .upd_valid_i(upd_valid_i),
    .upd_pc_i   (upd_pc_i),
    .upd_tgt_i  (upd_tgt_i),
    .upd_kind_i (upd_kind_i),
    .pred       (u_pred.producer)
  );

  rv_ras u_ras (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (ras_push),
    .pop_i      (ras_pop),
    .push_addr_i(ras_push_addr),
    .pred       (u_pred.producer)
  );

  rv_pc_sel u_pc_sel (
    .pc_i            (pc),
    .advance_i       (fetch_ready_i),
    .redirect_valid_i(redirect_valid_i),
    .redirect_tgt_i  (redirect_tgt_i),
    .pred            (u_pred.consumer),
    .pc_sel_o        (pc_sel),
    .pred_tgt_o      (pred_tgt),
    .redir_tgt_o     (redir_tgt),
    .ras_push_o      (ras_push),
    .ras_pop_o       (ras_pop),
    .ras_push_addr_o (ras_push_addr)
  );

  rv_stage_pc u_stage_pc (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_sel_i          (pc_sel),
    .redir_tgt_i       (redir_tgt),
    .pred_tgt_i        (pred_tgt),
    .pred              (u_pred.consumer),
    .fetch_ready_i     (fetch_ready_i),
    .pc_o              (pc),
    .fetch_valid_o     (fetch_valid_o),
    .pc_if_o           (pc_if_o),
    .pc_next_if_o      (pc_next_if_o),
    .btb_hit_if_o      (btb_hit_if_o),
    .btb_taken_if_o    (btb_taken_if_o),
    .btb_tgt_if_o      (btb_tgt_if_o),
    .btb_is_return_if_o(btb_is_return_if_o),
    .ras_valid_if_o    (ras_valid_if_o),
    .ras_tgt_if_o      (ras_tgt_if_o),
    .redir_pending_o   (redir_pending_o)
  );

endmodule

/* sim/rv_fetch_tb.sv */
`timescale 1ns/1ps

module rv_fetch_tb
  import rv_fetch_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  // Cycle budget per test, the watchdog allows twice the sum
  localparam int LEN_RESET  = 40;
  localparam int LEN_STALL  = 80;
  localparam int LEN_BRANCH = 30;
  localparam int LEN_CALL   = 40;
  localparam int LEN_REDIR  = 25;
  localparam int LEN_RET    = 25;
  localparam int TOTAL_CYCLES = LEN_RESET + LEN_STALL + LEN_BRANCH + LEN_CALL + LEN_REDIR
                                + LEN_RET;

  logic            clk;
  logic            rst_n;
  logic            fetch_ready_i;
  logic            redirect_valid_i;
  logic [XLEN-1:0] redirect_tgt_i;
  logic            upd_valid_i;
  logic [XLEN-1:0] upd_pc_i;
  logic [XLEN-1:0] upd_tgt_i;
  btb_kind_t       upd_kind_i;
  logic            fetch_valid_o;
  logic [XLEN-1:0] pc_if_o;
  logic [XLEN-1:0] pc_next_if_o;
  logic            btb_hit_if_o;
  logic            btb_taken_if_o;
  logic [XLEN-1:0] btb_tgt_if_o;
  logic            btb_is_return_if_o;
  logic            ras_valid_if_o;
  logic [XLEN-1:0] ras_tgt_if_o;
  logic            redir_pending_o;

  // Reference model state
  logic            model_live = 1'b0;
  logic [XLEN-1:0] m_pc;
  logic            m_btb_valid [BTB_ENTRIES];
  logic [XLEN-1:0] m_btb_pc    [BTB_ENTRIES];
  logic [XLEN-1:0] m_btb_tgt   [BTB_ENTRIES];
  btb_kind_t       m_btb_kind  [BTB_ENTRIES];
  logic [XLEN-1:0] m_ras [$];

  // Expected IF outputs
  logic            exp_valid;
  logic [XLEN-1:0] exp_pc_if;
  logic [XLEN-1:0] exp_pc_next_if;
  logic            exp_hit;
  logic            exp_taken;
  logic            exp_ret;
  logic            exp_ras_valid;
  logic            exp_redir;
  logic [XLEN-1:0] exp_btb_tgt;
  logic [XLEN-1:0] exp_ras_tgt;
  logic [XLEN-1:0] exp_flags;
  logic [XLEN-1:0] dut_flags;

  logic        rand_stall;
  logic [31:0] lfsr_q;
  string       current_test;
  int          errors;
  int          err_mark;
  int          tests_run;

  rv_fetch_top u_rv_fetch_top (.*);

  // Flag bits packed for one compare
  assign exp_flags = {{(XLEN-5){1'b0}}, exp_hit, exp_taken, exp_ret, exp_ras_valid, exp_redir};
  assign dut_flags = {{(XLEN-5){1'b0}}, btb_hit_if_o, btb_taken_if_o, btb_is_return_if_o,
                      ras_valid_if_o, redir_pending_o};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Back-pressure source, one LFSR step per ready bit
  initial begin : ready_gen
    lfsr_q = 32'ha04f;
    fetch_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      if (rand_stall) begin
        lfsr_q = lfsr_next(lfsr_q);
        fetch_ready_i <= lfsr_q[0];
      end else begin
        fetch_ready_i <= 1'b1;
      end
    end
  end

  // Model steps on the same edge as the DUT and sees the same inputs
  always @(posedge clk) begin : model
    logic [BTB_IDX_W-1:0] idx;
    logic                 hit;
    btb_kind_t            kind;
    logic                 rv;
    logic [XLEN-1:0]      rtop;
    logic [XLEN-1:0]      nxt;
    model_live <= 1'b1;
    if (!rst_n) begin
      m_pc <= RESET_PC;
      exp_valid <= 1'b0;
      exp_pc_if <= '0;
      exp_pc_next_if <= '0;
      exp_hit <= 1'b0;
      exp_taken <= 1'b0;
      exp_ret <= 1'b0;
      exp_ras_valid <= 1'b0;
      exp_redir <= 1'b0;
      exp_btb_tgt <= '0;
      exp_ras_tgt <= '0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
        m_btb_pc[i] = '0;
        m_btb_tgt[i] = '0;
        m_btb_kind[i] = BTB_BRANCH;
      end
      m_ras.delete();
    end else begin
      // Index from PC bits 5:2, tag is the rest above it
      idx  = m_pc[BTB_IDX_W+1:2];
      hit  = m_btb_valid[idx] && (m_btb_pc[idx][XLEN-1:BTB_IDX_W+2] == m_pc[XLEN-1:BTB_IDX_W+2]);
      kind = m_btb_kind[idx];
      rv   = (m_ras.size() > 0);
      rtop = '0;
      if (rv) begin
        rtop = m_ras[$];
      end
      // Redirect, then return with a valid stack, then branch or call
      if (redirect_valid_i) begin
        nxt = redirect_tgt_i;
      end else if (hit && kind == BTB_RETURN && rv) begin
        nxt = rtop;
      end else if (hit && kind != BTB_RETURN) begin
        nxt = m_btb_tgt[idx];
      end else begin
        nxt = m_pc + 32'd4;
      end
      exp_valid <= 1'b1;
      if (fetch_ready_i) begin
        m_pc <= nxt;
        exp_pc_if <= m_pc;
        exp_pc_next_if <= nxt;
        exp_hit <= hit;
        exp_taken <= hit && (kind != BTB_RETURN);
        exp_ret <= hit && (kind == BTB_RETURN);
        exp_ras_valid <= rv;
        exp_redir <= redirect_valid_i;
        exp_btb_tgt <= m_btb_tgt[idx];
        exp_ras_tgt <= rtop;
        // Stack keeps the newest RAS_DEPTH return addresses
        if (!redirect_valid_i && hit && kind == BTB_CALL) begin
          m_ras.push_back(m_pc + 32'd4);
          if (m_ras.size() > RAS_DEPTH) begin
            void'(m_ras.pop_front());
          end
        end else if (!redirect_valid_i && hit && kind == BTB_RETURN && rv) begin
          void'(m_ras.pop_back());
        end
      end
      // Training lands even on stalled cycles
      if (upd_valid_i) begin
        m_btb_valid[upd_pc_i[BTB_IDX_W+1:2]] = 1'b1;
        m_btb_pc[upd_pc_i[BTB_IDX_W+1:2]] = upd_pc_i;
        m_btb_tgt[upd_pc_i[BTB_IDX_W+1:2]] = upd_tgt_i;
        m_btb_kind[upd_pc_i[BTB_IDX_W+1:2]] = upd_kind_i;
      end
    end
  end

  task automatic report_mismatch(input string what, input logic [XLEN-1:0] exp_v,
                                 input logic [XLEN-1:0] act_v);
    errors++;
    $display("** Error [%s] %s: expected %h, actual %h", current_test, what, exp_v, act_v);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("** Error [%s] %s", current_test, what);
  endtask

  // Checks against the model
  a_reset_zero: assert property (@(posedge clk)
    model_live && !exp_valid |-> !fetch_valid_o && pc_if_o == '0 && pc_next_if_o == '0
                                 && dut_flags == '0)
    else report_failure("IF outputs were not cleared by reset");

  a_valid: assert property (@(posedge clk) model_live |-> fetch_valid_o == exp_valid)
    else report_mismatch("fetch_valid_o", XLEN'($sampled(exp_valid)),
                         XLEN'($sampled(fetch_valid_o)));

  a_pc_if: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> pc_if_o == exp_pc_if)
    else report_mismatch("pc_if_o", $sampled(exp_pc_if), $sampled(pc_if_o));

  a_pc_next_if: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> pc_next_if_o == exp_pc_next_if)
    else report_mismatch("pc_next_if_o", $sampled(exp_pc_next_if), $sampled(pc_next_if_o));

  // Hit, taken, return, ras_valid, redir_pending from high bit down
  a_flags: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> dut_flags == exp_flags)
    else report_mismatch("prediction flags", $sampled(exp_flags), $sampled(dut_flags));

  a_btb_tgt: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid && exp_hit |-> btb_tgt_if_o == exp_btb_tgt)
    else report_mismatch("btb_tgt_if_o", $sampled(exp_btb_tgt), $sampled(btb_tgt_if_o));

  a_ras_tgt: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid && exp_ras_valid |-> ras_tgt_if_o == exp_ras_tgt)
    else report_mismatch("ras_tgt_if_o", $sampled(exp_ras_tgt), $sampled(ras_tgt_if_o));

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid && !fetch_ready_i |=> $stable(pc_if_o) && $stable(pc_next_if_o)
                                    && $stable(dut_flags))
    else report_failure("IF outputs changed while fetch_ready_i was low");

  task automatic start_test(input string name);
    current_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("[%s] done, %0d errors", current_test, errors - err_mark);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!fetch_valid_o && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!fetch_valid_o) begin
      report_failure("fetch_valid_o never rose after reset");
    end
  endtask

  // One-cycle training write
  task automatic train(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                       input btb_kind_t kind);
    upd_valid_i <= 1'b1;
    upd_pc_i <= pc;
    upd_tgt_i <= tgt;
    upd_kind_i <= kind;
    @(posedge clk);
    upd_valid_i <= 1'b0;
  endtask

  // Held until an edge with fetch_ready_i high takes it
  task automatic redirect_to(input logic [XLEN-1:0] tgt);
    redirect_valid_i <= 1'b1;
    redirect_tgt_i <= tgt;
    do begin
      @(posedge clk);
    end while (!fetch_ready_i);
    redirect_valid_i <= 1'b0;
  endtask

  initial begin : watchdog
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: run still busy after %0d ns", TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    rst_n = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_tgt_i = '0;
    upd_valid_i = 1'b0;
    upd_pc_i = '0;
    upd_tgt_i = '0;
    upd_kind_i = BTB_BRANCH;
    rand_stall = 1'b0;
    errors = 0;
    tests_run = 0;
    current_test = "reset_seq";
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_seq");
    wait_valid();
    run_cycles(20);
    finish_test();

    start_test("random_stall");
    rand_stall <= 1'b1;
    run_cycles(60);
    rand_stall <= 1'b0;
    run_cycles(4);
    finish_test();

    // Taken branch, then an alias on the same index
    start_test("btb_branch");
    train(32'h0000_2008, 32'h0000_2100, BTB_BRANCH);
    redirect_to(32'h0000_2000);
    run_cycles(8);
    redirect_to(32'h0000_2040);
    run_cycles(8);
    finish_test();

    // Two nested calls, each return pops in reverse order
    start_test("call_return");
    train(32'h0000_3004, 32'h0000_3400, BTB_CALL);
    train(32'h0000_3408, 32'h0000_3800, BTB_CALL);
    train(32'h0000_380c, 32'h0000_0000, BTB_RETURN);
    train(32'h0000_3410, 32'h0000_0000, BTB_RETURN);
    redirect_to(32'h0000_3000);
    run_cycles(25);
    finish_test();

    // Redirect lands while the PC sits on a trained branch
    start_test("redirect");
    train(32'h0000_4008, 32'h0000_4200, BTB_BRANCH);
    redirect_to(32'h0000_4000);
    run_cycles(2);
    redirect_to(32'h0000_4500);
    run_cycles(10);
    finish_test();

    start_test("ret_empty");
    train(32'h0000_5008, 32'h0000_0000, BTB_RETURN);
    redirect_to(32'h0000_5000);
    run_cycles(10);
    finish_test();

    $display("Summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
hw/rv_fetch_pkg.sv
hw/rv_pred_if.sv
hw/rv_btb.sv
hw/rv_ras.sv
hw/rv_pc_sel.sv
hw/rv_pipe_reg.sv
hw/rv_stage_pc.sv
hw/rv_fetch_top.sv
sim/rv_fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= rv_fetch_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
